/* design/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath widths
`define RV_XLEN       32
`define RV_REG_BITS   5

// First fetch after reset
`define RV_RESET_ADDR 32'h0000_0000

// addi x0, x0, 0
`define RV_INSN_NOP   32'h0000_0013

// Instruction word fields
`define RV_OPC        6:0
`define RV_RD         11:7
`define RV_F3         14:12
`define RV_RS1        19:15
`define RV_RS2        24:20
`define RV_F7         31:25

`endif

/* design/rv_pkg.sv */
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_BITS-1:0] reg_idx_t;

    // Major opcodes kept in this core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
        ALU_SRA, ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_EXEC, ST_LDMEM, ST_STMEM, ST_TRAP
    } cpu_state_t;

endpackage

/* design/rv_mem_port.sv */
`timescale 1ns/100ps

module rv_mem_port
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       mem_req,
    input  logic       mem_we,
    input  logic       mem_is_insn,
    input  word_t      mem_req_addr,
    input  word_t      mem_req_wdata,
    output logic       mem_done,
    output word_t      rdata,
    output logic       mem_valid,
    output logic       mem_instr,
    input  logic       mem_ready,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic [3:0] mem_wstrb,
    input  word_t      mem_rdata
);
    typedef enum logic {MP_IDLE, MP_BUSY} mp_state_t;

    mp_state_t state;
    word_t     rdata_q;

    assign mem_valid = (state == MP_BUSY);
    assign mem_done  = mem_valid && mem_ready;

    // Bus word passes straight through on the accepting cycle, then held
    assign rdata = mem_done ? mem_rdata : rdata_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= MP_IDLE;
        end else begin
            case (state)
                MP_IDLE: if (mem_req) state <= MP_BUSY;
                MP_BUSY: if (mem_ready) state <= MP_IDLE;
                default: state <= MP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MP_IDLE && mem_req) begin
            mem_addr  <= mem_req_addr;
            mem_wdata <= mem_req_wdata;
            mem_wstrb <= mem_we ? 4'b1111 : 4'b0000;
            mem_instr <= mem_is_insn;
        end
        if (mem_done)
            rdata_q <= mem_rdata;
    end

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_decoder
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     insn_load,
    input  word_t    insn,
    output opcode_t  opcode,
    output alu_op_t  alu_op,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output logic     use_imm,
    output logic     illegal
);
    word_t      src;
    word_t      n_imm;
    alu_op_t    n_alu_op;
    logic       n_use_imm;
    logic       n_illegal;
    logic [2:0] f3;
    logic       alt;
    logic       f7_ok;

    // Under reset a NOP is decoded so all outputs start as a harmless ADDI
    assign src   = resetn ? insn : `RV_INSN_NOP;
    assign f3    = src[`RV_F3];
    assign alt   = (src[`RV_F7] == 7'b0100000);
    assign f7_ok = (src[`RV_F7] == 7'b0000000) || (alt && (f3 == 3'b000 || f3 == 3'b101));

    always_comb begin
        n_imm     = {{20{src[31]}}, src[31:20]};
        n_use_imm = 1'b1;
        n_illegal = 1'b0;

        // funct3 map shared by OP and OP_IMM
        case (f3)
            3'b000:  n_alu_op = ALU_ADD;
            3'b001:  n_alu_op = ALU_SLL;
            3'b010:  n_alu_op = ALU_SLT;
            3'b011:  n_alu_op = ALU_SLTU;
            3'b100:  n_alu_op = ALU_XOR;
            3'b101:  n_alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  n_alu_op = ALU_OR;
            default: n_alu_op = ALU_AND;
        endcase

        case (src[`RV_OPC])
            OPC_LUI, OPC_AUIPC: begin
                n_imm    = {src[31:12], 12'b0};
                n_alu_op = ALU_ADD;
            end
            OPC_JAL: begin
                n_imm    = {{12{src[31]}}, src[19:12], src[20], src[30:21], 1'b0};
                n_alu_op = ALU_ADD;
            end
            OPC_JALR: begin
                n_alu_op  = ALU_ADD;
                n_illegal = (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                n_imm     = {{20{src[31]}}, src[7], src[30:25], src[11:8], 1'b0};
                n_use_imm = 1'b0;
                case (f3)
                    3'b000:  n_alu_op = ALU_EQ;
                    3'b001:  n_alu_op = ALU_NE;
                    3'b100:  n_alu_op = ALU_SLT;
                    3'b101:  n_alu_op = ALU_GE;
                    3'b110:  n_alu_op = ALU_SLTU;
                    3'b111:  n_alu_op = ALU_GEU;
                    default: n_illegal = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                n_alu_op  = ALU_ADD;
                n_illegal = (f3 != 3'b010);
            end
            OPC_STORE: begin
                n_imm     = {{20{src[31]}}, src[31:25], src[11:7]};
                n_alu_op  = ALU_ADD;
                n_illegal = (f3 != 3'b010);
            end
            OPC_OP_IMM: begin
                // Only the shift forms constrain the upper bits
                n_illegal = (f3 == 3'b001 || f3 == 3'b101) && !f7_ok;
            end
            OPC_OP: begin
                n_use_imm = 1'b0;
                n_illegal = !f7_ok;
                if (f3 == 3'b000 && alt)
                    n_alu_op = ALU_SUB;
            end
            // SYSTEM included, so ECALL and EBREAK trap
            default: n_illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn || insn_load) begin
            opcode  <= opcode_t'(src[`RV_OPC]);
            alu_op  <= n_alu_op;
            rs1     <= src[`RV_RS1];
            rs2     <= src[`RV_RS2];
            rd      <= src[`RV_RD];
            imm     <= n_imm;
            use_imm <= n_use_imm;
            illegal <= n_illegal;
        end
    end

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     rd_we,
    input  reg_idx_t rd_addr,
    input  word_t    rd_data
);
    // x0 has no storage
    word_t regs [1:31];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rd_we && rd_addr != '0)
            regs[rd_addr] <= rd_data;
    end

endmodule

/* design/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu
    import rv_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    cond
);
    logic eq;
    logic lts;
    logic ltu;

    assign eq  = (a == b);
    assign lts = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    // Branch outcome
    always_comb begin
        case (op)
            ALU_EQ:   cond = eq;
            ALU_NE:   cond = !eq;
            ALU_SLT:  cond = lts;
            ALU_GE:   cond = !lts;
            ALU_SLTU: cond = ltu;
            ALU_GEU:  cond = !ltu;
            default:  cond = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << b[4:0];
            ALU_SLT:  result = word_t'(lts);
            ALU_SLTU: result = word_t'(ltu);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> b[4:0];
            ALU_SRA:  result = $signed(a) >>> b[4:0];
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = word_t'(cond);
        endcase
    end

endmodule

/* design/rv_control.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_control
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    output logic     mem_req,
    output logic     mem_we,
    output logic     mem_is_insn,
    output word_t    mem_req_addr,
    output word_t    mem_req_wdata,
    input  logic     mem_done,
    input  word_t    rdata,
    output logic     insn_load,
    input  opcode_t  opcode,
    input  word_t    imm,
    input  logic     use_imm,
    input  logic     illegal,
    input  reg_idx_t rd,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output word_t    alu_a,
    output word_t    alu_b,
    input  word_t    alu_result,
    input  logic     alu_cond,
    output logic     rd_we,
    output reg_idx_t rd_addr,
    output word_t    rd_data,
    output logic     trap
);
    cpu_state_t state;
    word_t      pc;
    word_t      pc_plus4;
    word_t      pc_imm;
    word_t      next_pc;
    logic       writes_rd;
    logic       is_jump;

    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + imm;
    assign is_jump  = (opcode == OPC_JAL) || (opcode == OPC_JALR);

    always_comb begin
        case (opcode)
            OPC_JAL:    next_pc = pc_imm;
            OPC_JALR:   next_pc = {alu_result[31:1], 1'b0};
            OPC_BRANCH: next_pc = alu_cond ? pc_imm : pc_plus4;
            default:    next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OP_IMM, OPC_OP: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // LUI adds to zero, AUIPC to the PC
    always_comb begin
        case (opcode)
            OPC_LUI:   alu_a = '0;
            OPC_AUIPC: alu_a = pc;
            default:   alu_a = rs1_data;
        endcase
    end
    assign alu_b = use_imm ? imm : rs2_data;

    assign insn_load = (state == ST_FETCH) && mem_done;
    assign rd_we     = (state == ST_EXEC && writes_rd) || (state == ST_LDMEM && mem_done);
    assign rd_addr   = rd;
    assign rd_data   = (state == ST_LDMEM) ? rdata : (is_jump ? pc_plus4 : alu_result);
    assign trap      = (state == ST_TRAP);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= ST_FETCH;
            pc           <= `RV_RESET_ADDR;
            mem_req      <= 1'b1;
            mem_we       <= 1'b0;
            mem_is_insn  <= 1'b1;
            mem_req_addr <= `RV_RESET_ADDR;
        end else begin
            case (state)
                ST_FETCH: begin
                    // Entered after a data access with no request pending
                    if (!mem_req) begin
                        mem_req      <= 1'b1;
                        mem_is_insn  <= 1'b1;
                        mem_req_addr <= pc;
                    end else if (mem_done) begin
                        mem_req <= 1'b0;
                        state   <= ST_DECODE;
                    end
                end
                ST_DECODE: state <= illegal ? ST_TRAP : ST_EXEC;
                ST_EXEC: begin
                    pc          <= next_pc;
                    mem_req     <= 1'b1;
                    mem_we      <= 1'b0;
                    mem_is_insn <= 1'b1;
                    case (opcode)
                        OPC_LOAD: begin
                            mem_req_addr <= alu_result;
                            mem_is_insn  <= 1'b0;
                            state        <= ST_LDMEM;
                        end
                        OPC_STORE: begin
                            mem_req_addr <= alu_result;
                            mem_we       <= 1'b1;
                            mem_is_insn  <= 1'b0;
                            state        <= ST_STMEM;
                        end
                        default: begin
                            mem_req_addr <= next_pc;
                            state        <= ST_FETCH;
                        end
                    endcase
                end
                ST_LDMEM, ST_STMEM: begin
                    if (mem_done) begin
                        mem_req <= 1'b0;
                        mem_we  <= 1'b0;
                        state   <= ST_FETCH;
                    end
                end
                default: state <= ST_TRAP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EXEC)
            mem_req_wdata <= rs2_data;
    end

endmodule

/* design/rv_core.sv */
`timescale 1ns/100ps

module rv_core (
    input  logic          clk,
    input  logic          resetn,
    output logic          mem_valid,
    output logic          mem_instr,
    input  logic          mem_ready,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic [3:0]    mem_wstrb,
    input  rv_pkg::word_t mem_rdata,
    output logic          trap
);
    logic             mem_req;
    logic             mem_we;
    logic             mem_is_insn;
    logic             mem_done;
    logic             insn_load;
    logic             use_imm;
    logic             illegal;
    logic             alu_cond;
    logic             rd_we;
    rv_pkg::word_t    mem_req_addr;
    rv_pkg::word_t    mem_req_wdata;
    rv_pkg::word_t    rdata;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;
    rv_pkg::word_t    alu_a;
    rv_pkg::word_t    alu_b;
    rv_pkg::word_t    alu_result;
    rv_pkg::word_t    rd_data;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rd_addr;
    rv_pkg::opcode_t  opcode;
    rv_pkg::alu_op_t  alu_op;

    rv_control u_control (
        .clk(clk), .resetn(resetn),
        .mem_req(mem_req), .mem_we(mem_we), .mem_is_insn(mem_is_insn),
        .mem_req_addr(mem_req_addr), .mem_req_wdata(mem_req_wdata),
        .mem_done(mem_done), .rdata(rdata),
        .insn_load(insn_load), .opcode(opcode), .imm(imm),
        .use_imm(use_imm), .illegal(illegal), .rd(rd),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result), .alu_cond(alu_cond),
        .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data),
        .trap(trap)
    );

    rv_mem_port u_mem_port (
        .clk(clk), .resetn(resetn),
        .mem_req(mem_req), .mem_we(mem_we), .mem_is_insn(mem_is_insn),
        .mem_req_addr(mem_req_addr), .mem_req_wdata(mem_req_wdata),
        .mem_done(mem_done), .rdata(rdata),
        .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_rdata(mem_rdata)
    );

    rv_decoder u_decoder (
        .clk(clk), .resetn(resetn), .insn_load(insn_load), .insn(rdata),
        .opcode(opcode), .alu_op(alu_op), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .use_imm(use_imm), .illegal(illegal)
    );

    rv_regfile u_regfile (
        .clk(clk), .rs1(rs1), .rs2(rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    rv_alu u_alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .cond(alu_cond)
    );

endmodule

/* tests/rv_core_assert.sv */
`timescale 1ns/100ps

module rv_core_assert
    import rv_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input logic       mem_valid,
    input logic       mem_ready,
    input word_t      mem_addr,
    input logic [3:0] mem_wstrb,
    input logic       trap
);
    // Request held until the memory accepts it
    a_bus_stable: assert property (@(posedge clk) disable iff (!resetn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wstrb))
        else $error("bus request changed before mem_ready");

    a_wstrb_legal: assert property (@(posedge clk) disable iff (!resetn)
        mem_valid |-> (mem_wstrb == 4'b1111 || mem_wstrb == 4'b0000))
        else $error("mem_wstrb is neither a full word nor a read");

    // Trap is sticky until reset
    a_trap_sticky: assert property (@(posedge clk) disable iff (!resetn)
        trap |=> trap)
        else $error("trap fell without a reset");

    a_no_bus_in_trap: assert property (@(posedge clk) disable iff (!resetn)
        $rose(mem_valid) |-> !trap)
        else $error("bus transfer started while trapped");

endmodule

bind rv_core rv_core_assert u_core_assert (
    .clk(clk), .resetn(resetn), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_wstrb(mem_wstrb), .trap(trap)
);

/* tests/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core
    import rv_pkg::*;
();
    // jal x0, 0
    localparam word_t HALT      = 32'h0000_006f;
    localparam int    MAX_TESTS = 40;
    localparam int    TIMEOUT   = 500;

    logic       clk;
    logic       resetn;
    logic       mem_valid;
    logic       mem_instr;
    logic       mem_ready;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [3:0] mem_wstrb;
    word_t      mem_rdata;
    logic       trap;

    word_t       mem [0:255];
    logic [31:0] lcg_state;
    logic [1:0]  waits_left;
    logic        pending;
    int          result_stores;
    word_t       cur_addr;
    word_t       cur_wdata;
    logic [3:0]  cur_wstrb;
    int          errors;
    int          failed_tests;
    int          cur_test;

    string t_name [MAX_TESTS];
    word_t t_prog [MAX_TESTS][8];
    word_t t_exp  [MAX_TESTS];
    logic  t_trap [MAX_TESTS];
    int    n_tests;

    rv_core i_dut (
        .clk(clk), .resetn(resetn),
        .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_rdata(mem_rdata), .trap(trap)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Opcode field is zero, so a stray fetch traps
    function automatic word_t fill_word(input int idx);
        return {16'hbad0, idx[7:0], 8'h00};
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
            input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
            input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input reg_idx_t rs2, input reg_idx_t rs1,
            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
            input reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [6:0] opc, input reg_idx_t rd,
            input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t addi(input reg_idx_t rd, input reg_idx_t rs1,
            input logic [11:0] imm);
        return i_type(7'b0010011, 3'b000, rd, rs1, imm);
    endfunction

    // Result word lives at byte 256, word 64
    function automatic word_t store_result(input reg_idx_t rs2);
        return s_type(rs2, 5'd0, 12'd256);
    endfunction

    // Memory model with 0 to 3 wait cycles per transfer
    initial begin
        mem_ready     = 1'b0;
        mem_rdata     = '0;
        pending       = 1'b0;
        waits_left    = 2'd0;
        result_stores = 0;
        lcg_state     = 32'h2a87_bb0a;
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready) begin
                // Handshake completed on the edge just passed
                mem_ready = 1'b0;
                if (cur_wstrb == 4'b1111) begin
                    mem[cur_addr[9:2]] = cur_wdata;
                    if (cur_addr[9:2] == 8'd64)
                        result_stores++;
                end else if (cur_wstrb != 4'b0000) begin
                    $display("[FAIL] %s: write strobe expected 1111, actual %b at %h",
                             t_name[cur_test], cur_wstrb, cur_addr);
                    errors++;
                end
            end else if (mem_valid) begin
                if (!pending) begin
                    lcg_state  = lcg_next(lcg_state);
                    waits_left = lcg_state[17:16];
                    pending    = 1'b1;
                end
                if (waits_left == 2'd0) begin
                    check_access(mem_addr, mem_instr, mem_wstrb);
                    cur_addr  = mem_addr;
                    cur_wdata = mem_wdata;
                    cur_wstrb = mem_wstrb;
                    mem_rdata = mem[mem_addr[9:2]];
                    mem_ready = 1'b1;
                    pending   = 1'b0;
                end else begin
                    waits_left = waits_left - 2'd1;
                end
            end
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_trap(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: trap expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Programs occupy words 0 to 7, so any other address is a data access
    task automatic check_access(input word_t addr, input logic instr,
            input logic [3:0] wstrb);
        logic exp_instr;
        exp_instr = (wstrb == 4'b0000) && (addr < 32'd32);
        if (addr[1:0] != 2'b00) begin
            $display("%s: bus access at unaligned address %h", t_name[cur_test], addr);
            errors++;
        end
        if (instr !== exp_instr) begin
            $display("[FAIL] %s: mem_instr at %h expected %b, actual %b",
                     t_name[cur_test], addr, exp_instr, instr);
            errors++;
        end
    endtask

    task automatic add_test(input string name, input word_t exp, input logic trp,
            input word_t p0, input word_t p1 = HALT, input word_t p2 = HALT,
            input word_t p3 = HALT, input word_t p4 = HALT, input word_t p5 = HALT,
            input word_t p6 = HALT, input word_t p7 = HALT);
        t_name[n_tests] = name;
        t_exp[n_tests]  = exp;
        t_trap[n_tests] = trp;
        t_prog[n_tests] = '{p0, p1, p2, p3, p4, p5, p6, p7};
        n_tests++;
    endtask

    // x1 = -20, x2 = 6, result of the register op in x3
    task automatic alu_test(input string name, input logic [6:0] f7, input logic [2:0] f3,
            input word_t exp);
        add_test(name, exp, 1'b0, addi(1, 0, -12'sd20), addi(2, 0, 12'd6),
                 r_type(f7, f3, 3, 1, 2), store_result(3));
    endtask

    // Marker ADDI at 16 runs only when the branch falls through
    task automatic branch_test(input string name, input logic [2:0] f3,
            input logic [11:0] a, input logic [11:0] b, input logic taken);
        add_test(name, taken ? 32'd1 : 32'd2, 1'b0, addi(1, 0, a), addi(2, 0, b),
                 addi(3, 0, 12'd1), b_type(f3, 1, 2, 13'd8), addi(3, 0, 12'd2),
                 store_result(3));
    endtask

    task automatic build_table();
        add_test("addi", 32'hffff_fff3, 1'b0, addi(1, 0, -12'sd20), addi(3, 1, 12'd7),
                 store_result(3));
        alu_test("add", 7'h00, 3'b000, 32'hffff_fff2);
        alu_test("sub", 7'h20, 3'b000, 32'hffff_ffe6);
        alu_test("sll", 7'h00, 3'b001, 32'hffff_fb00);
        alu_test("slt", 7'h00, 3'b010, 32'h0000_0001);
        alu_test("sltu", 7'h00, 3'b011, 32'h0000_0000);
        alu_test("xor", 7'h00, 3'b100, 32'hffff_ffea);
        alu_test("srl", 7'h00, 3'b101, 32'h03ff_ffff);
        alu_test("sra", 7'h20, 3'b101, 32'hffff_ffff);
        alu_test("or", 7'h00, 3'b110, 32'hffff_ffee);
        alu_test("and", 7'h00, 3'b111, 32'h0000_0004);
        add_test("srai", 32'hffff_fffb, 1'b0, addi(1, 0, -12'sd20),
                 i_type(7'b0010011, 3'b101, 3, 1, 12'h402), store_result(3));
        add_test("lui", 32'h1234_5000, 1'b0, u_type(7'b0110111, 3, 20'h12345),
                 store_result(3));
        add_test("auipc", 32'h0000_1004, 1'b0, addi(0, 0, 12'd0),
                 u_type(7'b0010111, 3, 20'h00001), store_result(3));
        branch_test("beq_taken", 3'b000, 12'd5, 12'd5, 1'b1);
        branch_test("beq_not_taken", 3'b000, 12'd5, 12'd6, 1'b0);
        branch_test("bne_taken", 3'b001, 12'd5, 12'd6, 1'b1);
        branch_test("bne_not_taken", 3'b001, 12'd5, 12'd5, 1'b0);
        branch_test("blt_taken", 3'b100, -12'sd1, 12'd1, 1'b1);
        branch_test("blt_not_taken", 3'b100, 12'd1, -12'sd1, 1'b0);
        branch_test("bge_taken", 3'b101, 12'd1, -12'sd1, 1'b1);
        branch_test("bge_not_taken", 3'b101, -12'sd1, 12'd1, 1'b0);
        branch_test("bltu_taken", 3'b110, 12'd1, -12'sd1, 1'b1);
        branch_test("bltu_not_taken", 3'b110, -12'sd1, 12'd1, 1'b0);
        branch_test("bgeu_taken", 3'b111, -12'sd1, 12'd1, 1'b1);
        branch_test("bgeu_not_taken", 3'b111, 12'd1, -12'sd1, 1'b0);
        // The skipped ADDIs would clobber the link register
        add_test("jal", 32'd8, 1'b0, addi(3, 0, 12'd9), j_type(1, 21'd8),
                 addi(1, 0, 12'd0), store_result(1));
        add_test("jalr", 32'd8, 1'b0, addi(2, 0, 12'd17),
                 i_type(7'b1100111, 3'b000, 1, 2, 12'd0), addi(1, 0, 12'd0),
                 addi(1, 0, 12'd0), store_result(1));
        add_test("sw_lw", 32'hcafe_1234, 1'b0, u_type(7'b0110111, 1, 20'hcafe1),
                 addi(1, 1, 12'h234), s_type(1, 0, 12'd260),
                 i_type(7'b0000011, 3'b010, 3, 0, 12'd260), store_result(3));
        add_test("x0_write", 32'd0, 1'b0, addi(3, 0, 12'd55), addi(0, 3, 12'd1),
                 store_result(0));
        add_test("illegal", fill_word(64), 1'b1, addi(3, 0, 12'd1), 32'hffff_ffff,
                 store_result(3));
        add_test("ebreak", fill_word(64), 1'b1, addi(3, 0, 12'd1), 32'h0010_0073,
                 store_result(3));
    endtask

    task automatic run_test(input int t);
        int errors_before;
        int stores_before;
        int cycles;
        int i;
        errors_before = errors;
        cur_test      = t;
        @(posedge clk);
        #1;
        resetn = 1'b0;
        @(negedge clk);
        for (i = 0; i < 256; i++)
            mem[i] = fill_word(i);
        for (i = 0; i < 8; i++)
            mem[i] = t_prog[t][i];
        stores_before = result_stores;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        cycles = 0;
        if (t_trap[t]) begin
            while (!trap && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!trap) begin
                $display("%s: trap did not rise within %0d cycles", t_name[t], TIMEOUT);
                errors++;
            end
        end else begin
            while (result_stores == stores_before && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (result_stores == stores_before) begin
                $display("%s: no store to the result word within %0d cycles",
                         t_name[t], TIMEOUT);
                errors++;
            end
        end
        // Let the core run on so a late trap or a stray store shows up
        repeat (20) @(negedge clk);
        check_word(t_name[t], t_exp[t], mem[64]);
        check_trap(t_name[t], t_trap[t], trap);
        if (errors == errors_before) begin
            $display("test %s: ok", t_name[t]);
        end else begin
            $display("test %s: %0d error(s)", t_name[t], errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        int t;
        resetn       = 1'b0;
        errors       = 0;
        failed_tests = 0;
        n_tests      = 0;
        cur_test     = 0;
        build_table();
        for (t = 0; t < n_tests; t++)
            run_test(t);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, n_tests - failed_tests, failed_tests, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+design
design/rv_pkg.sv
design/rv_mem_port.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_control.sv
design/rv_core.sv
tests/rv_core_assert.sv
tests/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
